// ==== hw/rv_pkg.sv ====
// RV64I base types
`default_nettype none

package rv_pkg;

  localparam int xlen  = 64;  // data path width
  localparam int ilen  = 32;  // instruction word width
  localparam int nregs = 32;  // architectural registers

  // major opcodes needed outside the decode tables
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  localparam logic [ilen-1:0] ebreak_word = 32'h00100073;  // exact encoding

  typedef logic [xlen-1:0]          xlen_t;     // register, imm, pc, result
  typedef logic [ilen-1:0]          inst_t;
  typedef logic [$clog2(nregs)-1:0] reg_idx_t;
  typedef logic [5:0]               shamt_t;    // rv64 shift amount

  typedef enum logic [4:0] {
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_bne,
    op_bge,
    op_addi,
    op_addiw,
    op_sltiu,
    op_xori,
    op_andi,
    op_slli,
    op_srli,
    op_srai,
    op_add,
    op_sub,
    op_sltu,
    op_or,
    op_and,
    op_addw,
    op_sllw,
    op_ebreak,
    op_illegal   // also the table miss value
  } op_t;

endpackage

`default_nettype wire

// ==== hw/core_if_pkg.sv ====
// Core interface records
`default_nettype none

package core_if_pkg;

  import rv_pkg::*;

  // request from the environment
  typedef struct packed {
    inst_t inst;
    xlen_t pc;
  } issue_t;

  // decoder output, imm already picked by format
  typedef struct packed {
    op_t      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    imm;
    shamt_t   shamt;
  } decoded_t;

  // one record per retired instruction
  typedef struct packed {
    reg_idx_t rd;
    logic     wen;      // low for x0 or non-writing ops
    xlen_t    wdata;
    xlen_t    next_pc;
    logic     ebreak;
    logic     illegal;
  } retire_t;

endpackage

`default_nettype wire

// ==== hw/mux_key.sv ====
// Keyed lookup mux
`timescale 1ns/1ps
`default_nettype none

module mux_key #(
  parameter int nr_key   = 2,
  parameter int key_len  = 1,
  parameter int data_len = 1
) (
  input  logic [key_len-1:0]                  key,
  input  logic [data_len-1:0]                 default_out,
  input  logic [nr_key*(key_len+data_len)-1:0] lut,  // {key, data} pairs
  output logic [data_len-1:0]                 out
);

  // each pair holds the key above its data, first listed pair at the top
  always_comb begin
    out = default_out;  // no hit
    for (int i = 0; i < nr_key; i++) begin
      if (lut[i*(key_len+data_len)+data_len +: key_len] == key) begin
        out = lut[i*(key_len+data_len) +: data_len];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/idu.sv ====
// RV64I instruction decoder
`timescale 1ns/1ps
`default_nettype none

module idu import rv_pkg::*, core_if_pkg::*; (
  input  inst_t    inst,
  output decoded_t dec
);

  logic [$bits(op_t)-1:0] hit_i;  // funct3+opcode forms
  logic [$bits(op_t)-1:0] hit_u;  // opcode only forms
  logic [$bits(op_t)-1:0] hit_r;  // funct7+funct3+opcode
  logic [$bits(op_t)-1:0] hit_s;  // funct6 shifts
  op_t                    op;
  xlen_t                  imm_i;
  xlen_t                  imm_s;
  xlen_t                  imm_b;
  xlen_t                  imm_u;
  xlen_t                  imm_j;

  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  mux_key #(.nr_key(8), .key_len(10), .data_len($bits(op_t))) u_tab_i (
    .key         ({inst[14:12], inst[6:0]}),
    .default_out (op_illegal),
    .lut ({
      10'b000_1100111, op_jalr,
      10'b001_1100011, op_bne,
      10'b101_1100011, op_bge,
      10'b000_0010011, op_addi,
      10'b011_0010011, op_sltiu,
      10'b100_0010011, op_xori,
      10'b111_0010011, op_andi,
      10'b000_0011011, op_addiw
    }),
    .out         (hit_i)
  );

  mux_key #(.nr_key(3), .key_len(7), .data_len($bits(op_t))) u_tab_u (
    .key         (inst[6:0]),
    .default_out (op_illegal),
    .lut ({
      opc_lui,   op_lui,
      opc_auipc, op_auipc,
      opc_jal,   op_jal
    }),
    .out         (hit_u)
  );

  mux_key #(.nr_key(7), .key_len(17), .data_len($bits(op_t))) u_tab_r (
    .key         ({inst[31:25], inst[14:12], inst[6:0]}),
    .default_out (op_illegal),
    .lut ({
      17'b0000000_000_0110011, op_add,
      17'b0100000_000_0110011, op_sub,
      17'b0000000_011_0110011, op_sltu,
      17'b0000000_110_0110011, op_or,
      17'b0000000_111_0110011, op_and,
      17'b0000000_000_0111011, op_addw,
      17'b0000000_001_0111011, op_sllw
    }),
    .out         (hit_r)
  );

  // shamt[5] sits in bit 25, so only funct6 is keyed
  mux_key #(.nr_key(3), .key_len(16), .data_len($bits(op_t))) u_tab_s (
    .key         ({inst[31:26], inst[14:12], inst[6:0]}),
    .default_out (op_illegal),
    .lut ({
      16'b000000_001_0010011, op_slli,
      16'b000000_101_0010011, op_srli,
      16'b010000_101_0010011, op_srai
    }),
    .out         (hit_s)
  );

  // tables are disjoint, at most one of them hits
  always_comb begin
    if (inst == ebreak_word) begin
      op = op_ebreak;
    end else if (op_t'(hit_i) != op_illegal) begin
      op = op_t'(hit_i);
    end else if (op_t'(hit_u) != op_illegal) begin
      op = op_t'(hit_u);
    end else if (op_t'(hit_r) != op_illegal) begin
      op = op_t'(hit_r);
    end else begin
      op = op_t'(hit_s);  // op_illegal on a full miss
    end
  end

  always_comb begin
    dec.op    = op;
    dec.rd    = inst[11:7];
    dec.rs1   = inst[19:15];
    dec.rs2   = inst[24:20];
    dec.shamt = inst[25:20];
    case (inst[6:0])  // format by major opcode
      opc_lui, opc_auipc: dec.imm = imm_u;
      opc_jal:            dec.imm = imm_j;
      opc_branch:         dec.imm = imm_b;
      opc_store:          dec.imm = imm_s;
      default:            dec.imm = imm_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/regfile.sv ====
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  output xlen_t    rdata1,
  output xlen_t    rdata2,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  xlen_t    wdata
);

  xlen_t regs [nregs];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin  // x0 is read only
      regs[waddr] <= wdata;
    end
  end

  // combinational read, x0 hardwired
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/exu.sv ====
// ALU and branch unit
`timescale 1ns/1ps
`default_nettype none

module exu import rv_pkg::*, core_if_pkg::*; (
  input  decoded_t dec,
  input  xlen_t    pc,
  input  xlen_t    src1,
  input  xlen_t    src2,
  output retire_t  ret
);

  xlen_t       result;
  xlen_t       pc_plus4;
  xlen_t       target;
  logic        writes;
  logic [31:0] add_w;
  logic [31:0] addi_w;
  logic [31:0] sll_w;

  // word results are sign extended from bit 31
  function automatic xlen_t sext_w(input logic [31:0] v);
    return {{(xlen-32){v[31]}}, v};
  endfunction

  assign pc_plus4 = pc + xlen_t'(4);
  assign add_w    = src1[31:0] + src2[31:0];
  assign addi_w   = src1[31:0] + dec.imm[31:0];
  assign sll_w    = src1[31:0] << src2[4:0];  // sllw uses 5 bits

  always_comb begin
    result = '0;
    writes = 1'b1;
    case (dec.op)
      op_lui:   result = dec.imm;
      op_auipc: result = pc + dec.imm;
      op_jal,
      op_jalr:  result = pc_plus4;  // link address
      op_addi:  result = src1 + dec.imm;
      op_addiw: result = sext_w(addi_w);
      op_sltiu: result = xlen_t'(src1 < dec.imm);
      op_xori:  result = src1 ^ dec.imm;
      op_andi:  result = src1 & dec.imm;
      op_slli:  result = src1 << dec.shamt;
      op_srli:  result = src1 >> dec.shamt;
      op_srai:  result = xlen_t'($signed(src1) >>> dec.shamt);
      op_add:   result = src1 + src2;
      op_sub:   result = src1 - src2;
      op_sltu:  result = xlen_t'(src1 < src2);
      op_or:    result = src1 | src2;
      op_and:   result = src1 & src2;
      op_addw:  result = sext_w(add_w);
      op_sllw:  result = sext_w(sll_w);
      default:  writes = 1'b0;  // branches, ebreak, illegal
    endcase
  end

  always_comb begin
    target = pc_plus4;
    case (dec.op)
      op_jal:  target = pc + dec.imm;
      op_jalr: target = (src1 + dec.imm) & ~xlen_t'(1);  // lsb cleared
      op_bne: begin
        if (src1 != src2) begin
          target = pc + dec.imm;
        end
      end
      op_bge: begin
        if ($signed(src1) >= $signed(src2)) begin
          target = pc + dec.imm;
        end
      end
      default: target = pc_plus4;
    endcase
  end

  always_comb begin
    ret.rd      = dec.rd;
    ret.wen     = writes && (dec.rd != '0);
    ret.wdata   = result;
    ret.next_pc = target;
    ret.ebreak  = (dec.op == op_ebreak);
    ret.illegal = (dec.op == op_illegal);
  end

endmodule

`default_nettype wire

// ==== hw/exec_core.sv ====
// Single issue execute core
`timescale 1ns/1ps
`default_nettype none

module exec_core import rv_pkg::*, core_if_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_req,
  output logic    in_ack,
  input  issue_t  issue,
  output logic    out_req,
  input  logic    out_ack,
  output retire_t retire
);

  typedef enum logic [1:0] {
    st_idle,
    st_exec,       // one cycle, regfile write at its end
    st_resp,       // out_req high, waiting for out_ack
    st_wait_drop   // both handshakes closing
  } state_t;

  state_t   state;
  issue_t   issue_q;   // latched request
  retire_t  retire_q;  // held while out_req is up
  decoded_t dec;
  xlen_t    src1;
  xlen_t    src2;
  retire_t  exu_ret;
  logic     rf_wen;

  assign rf_wen = (state == st_exec) && exu_ret.wen;  // single write per issue

  idu u_idu (
    .inst (issue_q.inst),
    .dec  (dec)
  );

  regfile u_rf (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .rdata1 (src1),
    .rdata2 (src2),
    .wen    (rf_wen),
    .waddr  (exu_ret.rd),
    .wdata  (exu_ret.wdata)
  );

  exu u_exu (
    .dec  (dec),
    .pc   (issue_q.pc),
    .src1 (src1),
    .src2 (src2),
    .ret  (exu_ret)
  );

  // out_req comes up two edges after in_req is sampled in idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      in_ack   <= 1'b0;
      out_req  <= 1'b0;
      issue_q  <= '0;
      retire_q <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (in_req) begin
            issue_q <= issue;
            in_ack  <= 1'b1;
            state   <= st_exec;
          end
        end
        st_exec: begin
          retire_q <= exu_ret;
          out_req  <= 1'b1;
          state    <= st_resp;
        end
        st_resp: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= st_wait_drop;
          end
        end
        st_wait_drop: begin
          if (!in_req && !out_ack) begin  // both sides released
            in_ack <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign retire = retire_q;

endmodule

`default_nettype wire

// ==== testbench/exec_core_sva.sv ====
// Exec core handshake assertions
`timescale 1ns/1ps
`default_nettype none

module exec_core_sva import rv_pkg::*, core_if_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     in_req,
  input logic     in_ack,
  input logic     out_req,
  input logic     out_ack,
  input retire_t  retire,
  input xlen_t    x0_value
);

  int fails = 0;

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_req && !out_ack |=> out_req && $stable(retire))
    else begin
      $error("out_req dropped or retire changed before out_ack");
      fails++;
    end

  a_ack_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(in_ack) |-> $past(in_req))
    else begin
      $error("in_ack rose without in_req");
      fails++;
    end

  // accept edge is in_req high while in_ack still low
  a_out_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(in_req && !in_ack, 2) |-> $rose(out_req))
    else begin
      $error("out_req did not rise two cycles after accept");
      fails++;
    end

  // stored x0 stays zero across writes aimed at it
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    x0_value == '0)
    else begin
      $error("x0 storage holds a nonzero value");
      fails++;
    end

endmodule

bind exec_core exec_core_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_req   (in_req),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_ack  (out_ack),
  .retire   (retire),
  .x0_value (u_rf.regs[0])
);

`default_nettype wire

// ==== testbench/tb_exec_core.sv ====
// Exec core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core import rv_pkg::*, core_if_pkg::*; ();

  logic    clk;
  logic    rst_n;
  logic    in_req;
  logic    in_ack;
  issue_t  issue;
  logic    out_req;
  logic    out_ack;
  retire_t retire;

  string   names [$];
  inst_t   insts [$];
  xlen_t   pcs [$];
  retire_t exps [$];
  int      seed = 32'h4a06;
  int      errors = 0;
  int      retired = 0;
  int      cycles = 0;
  int      limit = 0;  // set once the cases are known

  exec_core dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .in_ack  (in_ack),
    .issue   (issue),
    .out_req (out_req),
    .out_ack (out_ack),
    .retire  (retire)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge out_req) retired++;  // one rise per retired instruction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: no progress on the handshakes within %0d cycles", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_xlen(input string name, input string field,
                            input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", name, field, exp, act);
    end
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      errors++;
      $display("Error %s rd: expected x%0d, actual x%0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input string field,
                            input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Error %s %s: expected %b, actual %b", name, field, exp, act);
    end
  endtask

  // reads every non-comment line of the case file into the queues
  function automatic bit load_cases();
    int      fd;
    int      n;
    int      rd;
    int      wen;
    int      ebr;
    int      ill;
    string   line;
    string   name;
    inst_t   inst;
    xlen_t   pc;
    xlen_t   wdata;
    xlen_t   npc;
    retire_t exp;
    fd = $fopen("testbench/exec_core_cases.txt", "r");
    if (fd == 0) begin
      return 1'b0;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %d %d %h %h %d %d",
                    name, inst, pc, rd, wen, wdata, npc, ebr, ill);
        if (n == 9) begin
          exp.rd      = reg_idx_t'(rd);
          exp.wen     = (wen != 0);
          exp.wdata   = wdata;
          exp.next_pc = npc;
          exp.ebreak  = (ebr != 0);
          exp.illegal = (ill != 0);
          names.push_back(name);
          insts.push_back(inst);
          pcs.push_back(pc);
          exps.push_back(exp);
        end else begin
          errors++;
          $display("case file line could not be parsed: %s", line);
        end
      end
    end
    $fclose(fd);
    return 1'b1;
  endfunction

  // one full four-phase exchange on each side
  task automatic run_case(input int i);
    int delay;
    @(negedge clk);
    issue.inst = insts[i];
    issue.pc   = pcs[i];
    in_req     = 1'b1;
    while (!in_ack) @(negedge clk);
    in_req = 1'b0;
    while (!out_req) @(negedge clk);
    delay = $random(seed) & 3;  // back-pressure
    repeat (delay) @(negedge clk);
    check_reg_idx(names[i], exps[i].rd, retire.rd);
    check_flag(names[i], "wen", exps[i].wen, retire.wen);
    if (exps[i].wen) begin
      check_xlen(names[i], "wdata", exps[i].wdata, retire.wdata);
    end
    check_xlen(names[i], "next_pc", exps[i].next_pc, retire.next_pc);
    check_flag(names[i], "ebreak", exps[i].ebreak, retire.ebreak);
    check_flag(names[i], "illegal", exps[i].illegal, retire.illegal);
    out_ack = 1'b1;
    while (out_req) @(negedge clk);
    out_ack = 1'b0;
    while (in_ack) @(negedge clk);
  endtask

  initial begin
    rst_n   = 1'b0;
    in_req  = 1'b0;
    out_ack = 1'b0;
    issue   = '0;
    if (!load_cases()) begin
      $display("the case file testbench/exec_core_cases.txt could not be opened");
      $display("TB FAILED");
    end else begin
      limit = names.size() * 20 + 10;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      foreach (names[i]) begin
        run_case(i);
      end
      if (retired != names.size()) begin
        errors++;
        $display("%0d retire records seen for %0d cases", retired, names.size());
      end
      $display("%0d cases, %0d check errors, %0d assertion errors",
               names.size(), errors, dut0.u_sva.fails);
      if (errors == 0 && dut0.u_sva.fails == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/exec_core_cases.txt ====
# name inst pc, then expected rd wen wdata next_pc ebreak illegal
# inst, pc, wdata and next_pc in hex; rd and the flags in decimal
lui_pos 123450b7 1000 1 1 12345000 1004 0 0
lui_neg 80000137 1004 2 1 ffffffff80000000 1008 0 0
auipc_pos 00001197 1008 3 1 2008 100c 0 0
auipc_neg fffff217 100c 4 1 c 1010 0 0
addi_pos 06400293 1010 5 1 64 1014 0 0
addi_neg ffd00313 1014 6 1 fffffffffffffffd 1018 0 0
addi_max 7ff08393 1018 7 1 123457ff 101c 0 0
addiw_pos fff1041b 101c 8 1 7fffffff 1020 0 0
addiw_neg 0013049b 1020 9 1 fffffffffffffffe 1024 0 0
add 00628533 1024 10 1 61 1028 0 0
sub 406285b3 1028 11 1 67 102c 0 0
sltu 0062b633 102c 12 1 1 1030 0 0
or 0050e6b3 1030 13 1 12345064 1034 0 0
and 0063f733 1034 14 1 123457fd 1038 0 0
addw 005107bb 1038 15 1 ffffffff80000064 103c 0 0
sllw 00a3183b 103c 16 1 fffffffffffffffa 1040 0 0
slli 02129893 1040 17 1 c800000000 1044 0 0
srli 03c35913 1044 18 1 f 1048 0 0
srai 40415993 1048 19 1 fffffffff8000000 104c 0 0
xori fff2ca13 104c 20 1 ffffffffffffff9b 1050 0 0
andi 0f03fa93 1050 21 1 f0 1054 0 0
sltiu fff2bb13 1054 22 1 1 1058 0 0
jal 100000ef 2000 1 1 2004 2100 0 0
jal_x0 ff9ff06f 2010 0 0 0 2008 0 0
jalr 00368c67 3000 24 1 3004 12345066 0 0
bne_taken 00629863 4000 16 0 0 4010 0 0
bne_not 00529863 4010 16 0 0 4014 0 0
bge_not fe5350e3 4020 1 0 0 4024 0 0
bge_taken fe62d0e3 4030 1 0 0 4010 0 0
addi_x0 00728013 5000 0 0 0 5004 0 0
add_x0 00000cb3 5004 25 1 0 5008 0 0
ebreak 00100073 5008 0 0 0 500c 1 0
ld 0000bd03 500c 26 0 0 5010 0 1
sw 00512423 5010 8 0 0 5014 0 1
zero_word 00000000 5014 0 0 0 5018 0 1
add_link 001c0db3 5020 27 1 5008 5024 0 0

// ==== exec_core.f ====
hw/rv_pkg.sv
hw/core_if_pkg.sv
hw/mux_key.sv
hw/idu.sv
hw/regfile.sv
hw/exu.sv
hw/exec_core.sv
testbench/exec_core_sva.sv
testbench/tb_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_exec_core -f exec_core.f -o sim_exec_core

./obj_dir/sim_exec_core +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "simulator exited with an error status" >> sim.log
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
